// ==== common/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// program memory address, 8k words
// top five bits select the page for jumps
`define CPU_ROM_AW 13

// one instruction word per ROM location
`define CPU_INSTR_W 12

// nibble datapath
// registers, ALU, RAM words and both ports
`define CPU_DATA_W 4

// data RAM address, formed as {Y,X}
`define CPU_RAM_AW 8

`endif

// ==== common/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // one 12-bit word, decoded two ways depending on op
  typedef union packed {
    // alu, moves, memory and port instructions
    struct packed {
      logic [3:0] op;
      logic [1:0] rd;
      logic [1:0] rs;
      logic [3:0] imm;
    } reg_form;
    // jumps, target is the low byte inside the current page
    struct packed {
      logic [3:0] op;
      logic [7:0] target;
    } br_form;
  } instr_t;

  // opcodes
  localparam logic [3:0] OP_NOP  = 4'h0;
  localparam logic [3:0] OP_LDI  = 4'h1;
  localparam logic [3:0] OP_MOV  = 4'h2;
  localparam logic [3:0] OP_ADD  = 4'h3;
  localparam logic [3:0] OP_IN   = 4'h4;
  localparam logic [3:0] OP_SUB  = 4'h5;
  localparam logic [3:0] OP_AND  = 4'h6;
  localparam logic [3:0] OP_OR   = 4'h7;
  localparam logic [3:0] OP_XOR  = 4'h8;
  localparam logic [3:0] OP_ADDI = 4'h9;
  localparam logic [3:0] OP_LD   = 4'hA;
  localparam logic [3:0] OP_ST   = 4'hB;
  localparam logic [3:0] OP_OUT  = 4'hC;
  localparam logic [3:0] OP_JC   = 4'hD;
  localparam logic [3:0] OP_JZ   = 4'hE;
  localparam logic [3:0] OP_JP   = 4'hF;

  // register indices for rd and rs
  localparam logic [1:0] REG_A = 2'd0;
  localparam logic [1:0] REG_B = 2'd1;
  localparam logic [1:0] REG_X = 2'd2;
  localparam logic [1:0] REG_Y = 2'd3;

endpackage

`default_nettype wire

// ==== core/cpu_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_alu (
  input  logic [3:0]             op,
  input  logic [`CPU_DATA_W-1:0] a,
  input  logic [`CPU_DATA_W-1:0] b,
  output logic [`CPU_DATA_W-1:0] result,
  output logic                   carry,
  output logic                   zero
);
  import isa_pkg::*;

  // one extra bit on top for carry or borrow
  logic [`CPU_DATA_W:0] wide;

  always_comb begin
    case (op)
      OP_ADD, OP_ADDI: begin
        // carry out of bit 3
        wide = {1'b0, a} + {1'b0, b};
      end
      OP_SUB: begin
        // top bit goes high when b > a, i.e. a borrow
        wide = {1'b0, a} - {1'b0, b};
      end
      OP_AND: begin
        wide = {1'b0, a & b};
      end
      OP_OR: begin
        wide = {1'b0, a | b};
      end
      OP_XOR: begin
        wide = {1'b0, a ^ b};
      end
      default: begin
        // not an alu op, result is ignored by exec
        wide = '0;
      end
    endcase
  end

  assign result = wide[`CPU_DATA_W-1:0];
  // only used by exec for ADD, ADDI and SUB
  assign carry  = wide[`CPU_DATA_W];
  assign zero   = (result == '0);

endmodule

`default_nettype wire

// ==== core/cpu_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_fetch (
  input  logic                    clk,
  input  logic                    rst,
  output logic [`CPU_ROM_AW-1:0]  rom_addr,
  input  logic [`CPU_INSTR_W-1:0] rom_data,
  input  logic                    advance,
  input  logic                    pc_load,
  input  logic [7:0]              pc_target,
  output isa_pkg::instr_t         instr,
  output logic                    instr_valid
);

  logic [`CPU_ROM_AW-1:0]  pc;
  // copy of the ROM word, kept while exec stalls
  logic [`CPU_INSTR_W-1:0] instr_q;
  logic                    held;

  // pc is a register, so the ROM address is too
  assign rom_addr = pc;

  // step or jump only when exec says the instruction is done
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (advance) begin
      if (pc_load) begin
        // jumps stay inside the current page
        pc <= {pc[`CPU_ROM_AW-1:8], pc_target};
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

  // low for the one cycle the new word is in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      instr_valid <= 1'b0;
      held        <= 1'b0;
    end else begin
      instr_valid <= !advance;
      if (advance) begin
        held <= 1'b0;
      end else if (instr_valid) begin
        held <= 1'b1;
      end
    end
  end

  // capture on the first valid cycle
  always_ff @(posedge clk) begin
    if (instr_valid && !held) begin
      instr_q <= rom_data;
    end
  end

  // first cycle comes straight from the ROM, later ones from the copy
  assign instr = held ? instr_q : rom_data;

endmodule

`default_nettype wire

// ==== core/cpu_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_exec (
  input  logic                   clk,
  input  logic                   rst,
  input  isa_pkg::instr_t        instr,
  input  logic                   instr_valid,
  output logic                   advance,
  output logic                   pc_load,
  output logic [7:0]             pc_target,
  output logic [`CPU_RAM_AW-1:0] ram_addr,
  output logic [`CPU_DATA_W-1:0] ram_wdata,
  output logic                   ram_we,
  input  logic [`CPU_DATA_W-1:0] ram_rdata,
  input  logic [`CPU_DATA_W-1:0] k0,
  output logic                   push_valid,
  output logic [`CPU_DATA_W-1:0] push_data,
  input  logic                   push_ready
);
  import isa_pkg::*;

  logic [3:0]             op;
  logic [1:0]             rd;
  logic [1:0]             rs;
  logic [`CPU_DATA_W-1:0] imm;
  logic [`CPU_DATA_W-1:0] reg_a, reg_b, reg_x, reg_y;
  logic                   flag_c, flag_z;
  // second cycle of LD, RAM data is ready
  logic                   ld_wait;
  logic [`CPU_DATA_W-1:0] rd_val, rs_val, alu_b, alu_result, wr_data;
  logic                   alu_carry, alu_zero, is_arith, is_logic, wr_en;

  // op sits in the same bits in both views
  assign op        = instr.reg_form.op;
  assign rd        = instr.reg_form.rd;
  assign rs        = instr.reg_form.rs;
  assign imm       = instr.reg_form.imm;
  assign pc_target = instr.br_form.target;

  // register file read ports
  always_comb begin
    case (rd)
      REG_A:   rd_val = reg_a;
      REG_B:   rd_val = reg_b;
      REG_X:   rd_val = reg_x;
      default: rd_val = reg_y;
    endcase
    case (rs)
      REG_A:   rs_val = reg_a;
      REG_B:   rs_val = reg_b;
      REG_X:   rs_val = reg_x;
      default: rs_val = reg_y;
    endcase
  end

  assign is_arith = (op == OP_ADD) || (op == OP_ADDI) || (op == OP_SUB);
  assign is_logic = (op == OP_AND) || (op == OP_OR) || (op == OP_XOR);
  // ADDI takes the immediate as second operand
  assign alu_b    = (op == OP_ADDI) ? imm : rs_val;

  cpu_alu i_alu (
    .op     (op),
    .a      (rd_val),
    .b      (alu_b),
    .result (alu_result),
    .carry  (alu_carry),
    .zero   (alu_zero)
  );

  // Y is the high nibble of the RAM address
  assign ram_addr  = {reg_y, reg_x};
  assign ram_wdata = rs_val;
  assign push_data = rs_val;

  // per-opcode control, nothing happens without a valid word
  always_comb begin
    advance    = 1'b0;
    pc_load    = 1'b0;
    wr_en      = 1'b0;
    wr_data    = alu_result;
    ram_we     = 1'b0;
    push_valid = 1'b0;
    if (instr_valid) begin
      case (op)
        OP_NOP: begin
          advance = 1'b1;
        end
        OP_LDI, OP_MOV, OP_IN: begin
          wr_en   = 1'b1;
          advance = 1'b1;
          if (op == OP_LDI) begin
            wr_data = imm;
          end else if (op == OP_MOV) begin
            wr_data = rs_val;
          end else begin
            wr_data = k0;
          end
        end
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: begin
          wr_en   = 1'b1;
          advance = 1'b1;
        end
        OP_LD: begin
          // first cycle only issues the read
          wr_en   = ld_wait;
          wr_data = ram_rdata;
          advance = ld_wait;
        end
        OP_ST: begin
          ram_we  = 1'b1;
          advance = 1'b1;
        end
        OP_OUT: begin
          // held here until the port takes it
          push_valid = 1'b1;
          advance    = push_ready;
        end
        OP_JC: begin
          pc_load = flag_c;
          advance = 1'b1;
        end
        OP_JZ: begin
          pc_load = flag_z;
          advance = 1'b1;
        end
        OP_JP: begin
          pc_load = 1'b1;
          advance = 1'b1;
        end
        default: begin
          advance = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ld_wait <= 1'b0;
    end else begin
      // set for exactly one cycle per LD
      ld_wait <= instr_valid && (op == OP_LD) && !ld_wait;
    end
  end

  // register file write port
  always_ff @(posedge clk) begin
    if (rst) begin
      reg_a <= '0;
      reg_b <= '0;
      reg_x <= '0;
      reg_y <= '0;
    end else if (wr_en) begin
      case (rd)
        REG_A:   reg_a <= wr_data;
        REG_B:   reg_b <= wr_data;
        REG_X:   reg_x <= wr_data;
        default: reg_y <= wr_data;
      endcase
    end
  end

  // logic ops touch Z only, arithmetic updates both
  always_ff @(posedge clk) begin
    if (rst) begin
      flag_c <= 1'b0;
      flag_z <= 1'b0;
    end else if (instr_valid && (is_arith || is_logic)) begin
      flag_z <= alu_zero;
      if (is_arith) begin
        flag_c <= alu_carry;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/data_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module data_ram (
  input  logic                   clk,
  input  logic                   we,
  input  logic [`CPU_RAM_AW-1:0] addr,
  input  logic [`CPU_DATA_W-1:0] wdata,
  output logic [`CPU_DATA_W-1:0] rdata
);

  localparam int DEPTH = 1 << `CPU_RAM_AW;

  // 256 nibbles
  logic [`CPU_DATA_W-1:0] mem [0:DEPTH-1];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    // registered read, old data on a same-address write
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// ==== design/out_port.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module out_port (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push_valid,
  input  logic [`CPU_DATA_W-1:0] push_data,
  output logic                   push_ready,
  output logic                   out_valid,
  output logic [`CPU_DATA_W-1:0] out_data,
  input  logic                   out_ready
);

  // room when empty, or when the held word leaves this cycle
  assign push_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (push_ready) begin
      // refill or empty, depending on the push side
      out_valid <= push_valid;
    end
  end

  // payload only moves on an accepted push
  // while stalled push_ready is low, so data holds
  always_ff @(posedge clk) begin
    if (push_valid && push_ready) begin
      out_data <= push_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_top (
  input  logic                    clk,
  input  logic                    rst,
  output logic [`CPU_ROM_AW-1:0]  rom_addr,
  input  logic [`CPU_INSTR_W-1:0] rom_data,
  input  logic [`CPU_DATA_W-1:0]  k0,
  output logic [`CPU_DATA_W-1:0]  out_data,
  output logic                    out_valid,
  input  logic                    out_ready
);
  import isa_pkg::*;

  // fetch to exec
  instr_t                 instr;
  logic                   instr_valid;
  // exec back to fetch
  logic                   advance;
  logic                   pc_load;
  logic [7:0]             pc_target;
  // data RAM
  logic [`CPU_RAM_AW-1:0] ram_addr;
  logic [`CPU_DATA_W-1:0] ram_wdata;
  logic [`CPU_DATA_W-1:0] ram_rdata;
  logic                   ram_we;
  // exec into the output slice
  logic                   push_valid;
  logic [`CPU_DATA_W-1:0] push_data;
  logic                   push_ready;

  cpu_fetch i_fetch (
    .clk         (clk),
    .rst         (rst),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data),
    .advance     (advance),
    .pc_load     (pc_load),
    .pc_target   (pc_target),
    .instr       (instr),
    .instr_valid (instr_valid)
  );

  cpu_exec i_exec (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .instr_valid (instr_valid),
    .advance     (advance),
    .pc_load     (pc_load),
    .pc_target   (pc_target),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .ram_we      (ram_we),
    .ram_rdata   (ram_rdata),
    .k0          (k0),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_ready  (push_ready)
  );

  data_ram i_data_ram (
    .clk   (clk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  out_port i_out_port (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready)
  );

endmodule

`default_nettype wire

// ==== testbench/cpu_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_assertions (
  input logic                   clk,
  input logic                   rst,
  input logic                   out_valid,
  input logic                   out_ready,
  input logic [`CPU_DATA_W-1:0] out_data,
  input logic                   push_valid,
  input logic                   push_ready,
  input logic [`CPU_ROM_AW-1:0] rom_addr
);

  // slice empties on reset
  reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high after reset");

  // stalled word must not move
  hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("output changed while waiting for out_ready");

  // pc is always defined once out of reset
  rom_addr_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(rom_addr))
    else $error("rom_addr has unknown bits");

  // valid only comes from an accepted push
  valid_needs_push: assert property (@(posedge clk) disable iff (rst)
    $rose(out_valid) |-> $past(push_valid && push_ready))
    else $error("out_valid rose without a push");

endmodule

bind cpu_top cpu_assertions i_cpu_assertions (.*);

`default_nettype wire

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_tb;

  logic                    clk;
  logic                    rst;
  logic [`CPU_ROM_AW-1:0]  rom_addr;
  logic [`CPU_INSTR_W-1:0] rom_data;
  logic [`CPU_DATA_W-1:0]  k0;
  logic [`CPU_DATA_W-1:0]  out_data;
  logic                    out_valid;
  logic                    out_ready;

  // program memory outside the core
  logic [`CPU_INSTR_W-1:0] rom [0:4095];

  // flattened case file, one record per word, k0, expected nibble or end mark
  byte                     rec_kind[$];
  int                      rec_addr[$];
  int                      rec_val[$];
  logic [`CPU_DATA_W-1:0]  expected[$];

  int                      cycle_limit;
  int                      cycles;
  int                      tests;
  int                      checks;
  int                      errors;
  int                      test_errors;

  cpu_top i_cpu_top (
    .clk       (clk),
    .rst       (rst),
    .rom_addr  (rom_addr),
    .rom_data  (rom_data),
    .k0        (k0),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ROM answers one clock after the address
  always @(posedge clk) begin
    rom_data <= rom[rom_addr[11:0]];
  end

  // watchdog, limit comes from the case file
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, outputs never arrived", cycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic load_cases();
    int  fd;
    int  code;
    int  addr;
    int  count;
    int  word;
    int  c;
    byte kind;
    fd = $fopen("testbench/cpu_cases.mem", "r");
    if (fd == 0) begin
      $display("cannot open testbench/cpu_cases.mem");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, " %c", kind);
        if (code == 1) begin
          case (kind)
            "#": begin
              c = 0;
              while (c != 10 && c != -1) begin
                c = $fgetc(fd);
              end
            end
            "P": begin
              code = $fscanf(fd, " %h %h", addr, count);
              for (int n = 0; n < count; n++) begin
                code = $fscanf(fd, " %h", word);
                rec_kind.push_back("P");
                rec_addr.push_back(addr + n);
                rec_val.push_back(word);
                cycle_limit += 8;
              end
            end
            "K", "E": begin
              code = $fscanf(fd, " %h", word);
              rec_kind.push_back(kind);
              rec_addr.push_back(0);
              rec_val.push_back(word);
              if (kind == "E") begin
                cycle_limit += 20;
              end
            end
            "T": begin
              rec_kind.push_back("T");
              rec_addr.push_back(0);
              rec_val.push_back(0);
              cycle_limit += 10;
            end
            default: begin
              $display("unknown line kind in case file");
              errors++;
            end
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_nibble(input string name, input logic [`CPU_DATA_W-1:0] got,
                              input logic [`CPU_DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  // sample at the falling edge, transfer happens on the next rising edge
  task automatic collect_outputs();
    int got_count;
    int tail;
    got_count   = 0;
    tail        = 0;
    test_errors = 0;
    while (got_count < expected.size() || tail < 8) begin
      @(negedge clk);
      if (out_valid && out_ready) begin
        if (got_count < expected.size()) begin
          check_nibble("out_data", out_data, expected[got_count]);
        end else begin
          $display("case %0d sent an extra output %h after all %0d expected ones",
                   tests, out_data, expected.size());
          test_errors++;
        end
        got_count++;
      end
      if (got_count >= expected.size()) begin
        tail++;
      end
      @(posedge clk);
      #1;
      // low about a third of the time
      out_ready = ($urandom % 3) != 0;
    end
    errors += test_errors;
    if (test_errors == 0) begin
      $display("case %0d ok, %0d outputs", tests, got_count);
    end else begin
      $display("case %0d had %0d errors", tests, test_errors);
    end
  endtask

  initial begin
    int i;
    rst         = 1'b1;
    k0          = '0;
    out_ready   = 1'b0;
    rom_data    = '0;
    cycles      = 0;
    cycle_limit = 0;
    tests       = 0;
    checks      = 0;
    errors      = 0;
    void'($urandom(21853));
    load_cases();
    i = 0;
    while (i < rec_kind.size()) begin
      // hold the core in reset while the ROM is swapped
      @(posedge clk);
      #1;
      rst       = 1'b1;
      out_ready = 1'b0;
      k0        = '0;
      for (int a = 0; a < 4096; a++) begin
        rom[a] = '0;
      end
      expected.delete();
      while (i < rec_kind.size() && rec_kind[i] != "T") begin
        case (rec_kind[i])
          "P": rom[rec_addr[i][11:0]] = rec_val[i][`CPU_INSTR_W-1:0];
          "K": k0 = rec_val[i][`CPU_DATA_W-1:0];
          default: expected.push_back(rec_val[i][`CPU_DATA_W-1:0]);
        endcase
        i++;
      end
      i++;
      tests++;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      collect_outputs();
    end
    $display("%0d cases, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/cpu_cases.mem ====
# P start_addr word_count words... | K k0 | E expected_out | T end of case
# all values hex, instruction = op rd rs imm, jumps = op target
# case 1 arithmetic, carry and borrow through JC
P 000 8 109 148 310 C00 D06 C10 947 C10
P 008 8 D0A C00 103 510 C00 D0F C10 540
P 010 2 C10 F11
E 1
E F
E 1
E 4
E B
T
# case 2 logic ops, Z through JZ, C kept across logic
P 000 8 10F 141 310 10C 14A 610 C00 D09
P 008 8 C10 740 C10 E0D 810 C00 851 E11
P 010 5 C00 C10 D14 C00 F14
E 8
E A
E 2
E 0
T
# case 3 RAM at {Y,X}, read back in another order
P 000 8 185 1C3 107 B00 1C6 109 B00 18E
P 008 8 142 B10 185 A00 C00 1C3 A40 C10
P 010 5 1C6 18E A00 C00 F14
E 9
E 7
E 2
T
# case 4 input port
K 6
P 000 7 400 C00 90C C00 440 C10 F06
E 6
E 2
E 6
T
# case 5 long OUT run under back-pressure, JP skips a bad OUT
P 000 8 F02 C00 101 142 C00 C10 902 C00
P 008 8 C00 340 C10 C00 18E C20 C10 C20
P 010 5 983 C20 C00 C10 F14
E 1
E 2
E 3
E 3
E 5
E 3
E E
E 5
E E
E 1
E 3
E 5
T

// ==== compile.f ====
+incdir+common
common/isa_pkg.sv
core/cpu_alu.sv
core/cpu_fetch.sv
core/cpu_exec.sv
design/data_ram.sv
design/out_port.sv
design/cpu_top.sv
testbench/cpu_assertions.sv
testbench/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module cpu_tb -o sim_cpu

./obj_dir/sim_cpu | tee sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
